//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tagePredictor_tb
FILELIST  := build.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf $(OBJDIR)

//--- build.f
+incdir+src
src/tagePkg.sv
src/tableLookupIf.sv
src/historyHasher.sv
src/bimodalTable.sv
src/tageTable.sv
src/predictSelect.sv
src/tagePredictor.sv
test/tagePredictor_chk.sv
test/tagePredictor_tb.sv

//--- src/bimodalTable.sv
`timescale 1ns/1ns
`include "tage_defines.svh"

module bimodalTable (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [$clog2(`BIM_SIZE)-1:0] readIdx,
    input  logic                         writeValid,
    input  logic [$clog2(`BIM_SIZE)-1:0] writeIdx,
    input  logic                         writeTaken,
    output logic                         readTaken
);
    logic [`CNT_W-1:0] counters [`BIM_SIZE];
    logic [`CNT_W-1:0] cur;

    assign readTaken = counters[readIdx][`CNT_W-1];
    assign cur       = counters[writeIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BIM_SIZE; i++)
                counters[i] <= `CNT_W'(1); // weakly not-taken.
        end else if (writeValid) begin
            if (writeTaken && cur != {`CNT_W{1'b1}})
                counters[writeIdx] <= cur + 1'b1;
            else if (!writeTaken && cur != {`CNT_W{1'b0}})
                counters[writeIdx] <= cur - 1'b1;
        end
    end
endmodule

//--- src/historyHasher.sv
`timescale 1ns/1ns
`include "tage_defines.svh"

module historyHasher (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           predictValid,
    input  logic [31:0]                    predictPc,
    input  logic                           updateValid,
    input  logic [31:0]                    updatePc,
    input  logic                           updateTaken,
    input  tagePkg::predMeta_t             updateMeta,
    output logic                           stageValid,
    output logic [$clog2(`BIM_SIZE)-1:0]   bimPredIdx,
    output logic [$clog2(`BIM_SIZE)-1:0]   bimUpdIdx,
    output logic                           updValid,
    output logic                           updTaken,
    output tagePkg::predMeta_t             updMeta,
    tableLookupIf.hasher                   t1,
    tableLookupIf.hasher                   t2
);
    import tagePkg::*;

    localparam int IDX_W = $clog2(`TAGE_SIZE);
    localparam int BIM_W = $clog2(`BIM_SIZE);

    logic [`HIST2_LEN-1:0] hist;
    logic [IDX_W-1:0]      pIdx1, pIdx2, uIdx1, uIdx2;
    logic [`HIST2_LEN-1:0] pTag1, pTag2, uTag1, uTag2;

    // xor the first len history bits down onto w bit positions.
    function automatic logic [`HIST2_LEN-1:0] foldHist(
        input logic [`HIST2_LEN-1:0] h,
        input int len,
        input int w
    );
        logic [`HIST2_LEN-1:0] f;
        f = '0;
        for (int i = 0; i < `HIST2_LEN; i++) begin
            if (i < len)
                f[i % w] = f[i % w] ^ h[i];
        end
        return f;
    endfunction

    function automatic logic [IDX_W-1:0] calcIdx(
        input logic [31:0] pc,
        input logic [`HIST2_LEN-1:0] h,
        input int len
    );
        logic [`HIST2_LEN-1:0] f;
        f = foldHist(h, len, IDX_W);
        return pc[2 +: IDX_W] ^ f[IDX_W-1:0];
    endfunction

    // tag zero marks an empty entry, so the hash never produces it.
    function automatic logic [`HIST2_LEN-1:0] calcTag(
        input logic [31:0] pc,
        input logic [`HIST2_LEN-1:0] h,
        input int len,
        input int w
    );
        logic [`HIST2_LEN-1:0] t;
        t = (pc[8 +: `HIST2_LEN] ^ foldHist(h, len, w)) & ((`HIST2_LEN'(1) << w) - 1'b1);
        if (t == '0)
            t = `HIST2_LEN'(1);
        return t;
    endfunction

    always_comb begin
        pIdx1 = calcIdx(predictPc, hist, `HIST1_LEN);
        pIdx2 = calcIdx(predictPc, hist, `HIST2_LEN);
        pTag1 = calcTag(predictPc, hist, `HIST1_LEN, `TAG1_W);
        pTag2 = calcTag(predictPc, hist, `HIST2_LEN, `TAG2_W);
        uIdx1 = calcIdx(updatePc, hist, `HIST1_LEN);
        uIdx2 = calcIdx(updatePc, hist, `HIST2_LEN);
        uTag1 = calcTag(updatePc, hist, `HIST1_LEN, `TAG1_W);
        uTag2 = calcTag(updatePc, hist, `HIST2_LEN, `TAG2_W);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
            updValid   <= 1'b0;
            hist       <= '0;
        end else begin
            stageValid <= predictValid;
            updValid   <= updateValid;
            if (updValid)
                hist <= {hist[`HIST2_LEN-2:0], updTaken}; // shifts one edge after the update.
        end
    end

    always_ff @(posedge clk) begin
        if (predictValid) begin
            bimPredIdx  <= predictPc[2 +: BIM_W];
            t1.readAddr <= pIdx1;
            t1.readTag  <= pTag1[`TAG1_W-1:0];
            t2.readAddr <= pIdx2;
            t2.readTag  <= pTag2[`TAG2_W-1:0];
        end
        if (updateValid) begin
            bimUpdIdx    <= updatePc[2 +: BIM_W];
            t1.writeAddr <= uIdx1;
            t1.writeTag  <= uTag1[`TAG1_W-1:0];
            t2.writeAddr <= uIdx2;
            t2.writeTag  <= uTag2[`TAG2_W-1:0];
            updTaken     <= updateTaken;
            updMeta      <= updateMeta;
        end
    end
endmodule

//--- src/predictSelect.sv
`timescale 1ns/1ns

module predictSelect (
    input  logic               clk,
    input  logic               rst,
    input  logic               stageValid,
    input  logic               bimTaken,
    input  logic               updValid,
    input  logic               updTaken,
    input  tagePkg::predMeta_t updMeta,
    output logic               bimWrite,
    output logic               resultValid,
    output logic               resultTaken,
    output tagePkg::predMeta_t resultMeta,
    tableLookupIf.select       t1,
    tableLookupIf.select       t2
);
    import tagePkg::*;

    provider_t provider;
    logic      provTaken;
    logic      altTaken;
    logic      mispredict;
    logic      allocT1;
    logic      allocT2;
    logic      allocFail;

    always_comb begin
        if (t2.hit) begin
            provider  = T2;
            provTaken = t2.taken;
            altTaken  = t1.hit ? t1.taken : bimTaken;
        end else if (t1.hit) begin
            provider  = T1;
            provTaken = t1.taken;
            altTaken  = bimTaken;
        end else begin
            provider  = BASE;
            provTaken = bimTaken;
            altTaken  = bimTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            resultTaken <= 1'b0;
            resultMeta  <= '0;
        end else begin
            resultValid <= stageValid;
            if (stageValid) begin
                resultTaken              <= provTaken;
                resultMeta.provider      <= provider;
                resultMeta.altTaken      <= altTaken;
                resultMeta.providerTaken <= provTaken;
            end
        end
    end

    // The longest table never allocates, there is nothing above it.
    always_comb begin
        mispredict = updValid && updMeta.providerTaken != updTaken && updMeta.provider != T2;
        allocT1    = mispredict && updMeta.provider == BASE && t1.allocAvail;
        allocT2    = mispredict && !allocT1 && t2.allocAvail;
        allocFail  = mispredict && !allocT1 && !allocT2;

        bimWrite = updValid && updMeta.provider == BASE;

        t1.writeValid   = updValid;
        t1.writeUpdate  = updValid && updMeta.provider == T1;
        t1.writeUseful  = updMeta.altTaken != updMeta.providerTaken;
        t1.writeCorrect = updMeta.providerTaken == updTaken;
        t1.writeTaken   = updTaken;
        t1.doAlloc      = allocT1;
        t1.allocFailed  = allocFail && updMeta.provider == BASE;

        t2.writeValid   = updValid;
        t2.writeUpdate  = updValid && updMeta.provider == T2;
        t2.writeUseful  = updMeta.altTaken != updMeta.providerTaken;
        t2.writeCorrect = updMeta.providerTaken == updTaken;
        t2.writeTaken   = updTaken;
        t2.doAlloc      = allocT2;
        t2.allocFailed  = allocFail;
    end
endmodule

//--- src/tableLookupIf.sv
`timescale 1ns/1ns
`include "tage_defines.svh"

interface tableLookupIf #(
    parameter int TAG_W = `TAG1_W
);
    logic [$clog2(`TAGE_SIZE)-1:0] readAddr;
    logic [TAG_W-1:0]              readTag;
    logic                          hit;
    logic                          taken;
    logic                          allocAvail;

    logic [$clog2(`TAGE_SIZE)-1:0] writeAddr;
    logic [TAG_W-1:0]              writeTag;
    logic                          writeValid;
    logic                          writeUpdate;
    logic                          writeUseful;
    logic                          writeCorrect;
    logic                          writeTaken;
    logic                          doAlloc;
    logic                          allocFailed;

    modport hasher (output readAddr, readTag, writeAddr, writeTag);

    modport tbl (
        input  readAddr, readTag, writeAddr, writeTag,
        input  writeValid, writeUpdate, writeUseful, writeCorrect, writeTaken,
        input  doAlloc, allocFailed,
        output hit, taken, allocAvail
    );

    modport select (
        input  hit, taken, allocAvail,
        output writeValid, writeUpdate, writeUseful, writeCorrect, writeTaken,
        output doAlloc, allocFailed
    );
endinterface

//--- src/tagePkg.sv
package tagePkg;

`include "tage_defines.svh"

    typedef struct packed {
        logic [`TAG1_W-1:0] tag;
        logic [`USF_W-1:0]  useful;
        logic [`CNT_W-1:0]  counter;
    } tageEntry1_t;

    typedef struct packed {
        logic [`TAG2_W-1:0] tag;
        logic [`USF_W-1:0]  useful;
        logic [`CNT_W-1:0]  counter;
    } tageEntry2_t;

    // which component supplied the final direction.
    typedef enum logic [1:0] {
        BASE = 2'd0,
        T1   = 2'd1,
        T2   = 2'd2
    } provider_t;

    // travels with a prediction and comes back with its update.
    typedef struct packed {
        provider_t provider;
        logic      altTaken;
        logic      providerTaken;
    } predMeta_t;

endpackage

//--- src/tagePredictor.sv
`timescale 1ns/1ns
`include "tage_defines.svh"

module tagePredictor (
    input  logic               clk,
    input  logic               rst,
    input  logic               predictValid,
    input  logic [31:0]        predictPc,
    input  logic               updateValid,
    input  logic [31:0]        updatePc,
    input  logic               updateTaken,
    input  tagePkg::predMeta_t updateMeta,
    output logic               resultValid,
    output logic               resultTaken,
    output tagePkg::predMeta_t resultMeta
);
    import tagePkg::*;

    logic                         stageValid;
    logic [$clog2(`BIM_SIZE)-1:0] bimPredIdx;
    logic [$clog2(`BIM_SIZE)-1:0] bimUpdIdx;
    logic                         bimTaken;
    logic                         bimWrite;
    logic                         updValid;
    logic                         updTaken;
    predMeta_t                    updMeta;

    tableLookupIf #(.TAG_W(`TAG1_W)) t1If ();
    tableLookupIf #(.TAG_W(`TAG2_W)) t2If ();

    historyHasher hasher (
        .clk          (clk),
        .rst          (rst),
        .predictValid (predictValid),
        .predictPc    (predictPc),
        .updateValid  (updateValid),
        .updatePc     (updatePc),
        .updateTaken  (updateTaken),
        .updateMeta   (updateMeta),
        .stageValid   (stageValid),
        .bimPredIdx   (bimPredIdx),
        .bimUpdIdx    (bimUpdIdx),
        .updValid     (updValid),
        .updTaken     (updTaken),
        .updMeta      (updMeta),
        .t1           (t1If.hasher),
        .t2           (t2If.hasher)
    );

    bimodalTable bimTable (
        .clk        (clk),
        .rst        (rst),
        .readIdx    (bimPredIdx),
        .writeValid (bimWrite),
        .writeIdx   (bimUpdIdx),
        .writeTaken (updTaken),
        .readTaken  (bimTaken)
    );

    tageTable #(.entry_t(tageEntry1_t)) t1Table (
        .clk    (clk),
        .rst    (rst),
        .lookup (t1If.tbl)
    );

    tageTable #(.entry_t(tageEntry2_t)) t2Table (
        .clk    (clk),
        .rst    (rst),
        .lookup (t2If.tbl)
    );

    predictSelect select (
        .clk         (clk),
        .rst         (rst),
        .stageValid  (stageValid),
        .bimTaken    (bimTaken),
        .updValid    (updValid),
        .updTaken    (updTaken),
        .updMeta     (updMeta),
        .bimWrite    (bimWrite),
        .resultValid (resultValid),
        .resultTaken (resultTaken),
        .resultMeta  (resultMeta),
        .t1          (t1If.select),
        .t2          (t2If.select)
    );
endmodule

//--- src/tageTable.sv
`timescale 1ns/1ns
`include "tage_defines.svh"

module tageTable #(
    parameter type entry_t = tagePkg::tageEntry1_t
) (
    input logic       clk,
    input logic       rst,
    tableLookupIf.tbl lookup
);
    entry_t                   entries [`TAGE_SIZE];
    entry_t                   wrEntry;
    logic [`AGE_INTERVAL-1:0] decrCnt;
    logic                     decrBit;

    assign wrEntry = entries[lookup.writeAddr];

    always_comb begin
        lookup.hit        = entries[lookup.readAddr].tag == lookup.readTag;
        lookup.taken      = entries[lookup.readAddr].counter[`CNT_W-1];
        lookup.allocAvail = wrEntry.useful == '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decrCnt <= '0;
            decrBit <= 1'b0;
            for (int i = 0; i < `TAGE_SIZE; i++)
                entries[i] <= '0;
        end else begin
            if (lookup.writeValid) begin
                if (lookup.writeUpdate) begin
                    if (lookup.writeTaken && wrEntry.counter != {`CNT_W{1'b1}})
                        entries[lookup.writeAddr].counter <= wrEntry.counter + 1'b1;
                    else if (!lookup.writeTaken && wrEntry.counter != {`CNT_W{1'b0}})
                        entries[lookup.writeAddr].counter <= wrEntry.counter - 1'b1;

                    // only trained when the alternate would have disagreed.
                    if (lookup.writeUseful) begin
                        if (lookup.writeCorrect && wrEntry.useful != {`USF_W{1'b1}})
                            entries[lookup.writeAddr].useful <= wrEntry.useful + 1'b1;
                        else if (!lookup.writeCorrect && wrEntry.useful != {`USF_W{1'b0}})
                            entries[lookup.writeAddr].useful <= wrEntry.useful - 1'b1;
                    end
                end else if (lookup.doAlloc) begin
                    if (wrEntry.useful == '0) begin
                        entries[lookup.writeAddr].tag     <= lookup.writeTag;
                        entries[lookup.writeAddr].useful  <= '0;
                        entries[lookup.writeAddr].counter <=
                            {lookup.writeTaken, {(`CNT_W-1){!lookup.writeTaken}}};
                    end
                end else if (lookup.allocFailed) begin
                    if (wrEntry.useful != '0)
                        entries[lookup.writeAddr].useful <= wrEntry.useful - 1'b1;
                end
            end

            // Aging takes one bit off every useful counter, low and high in turn.
            if (decrCnt == '0) begin
                for (int i = 0; i < `TAGE_SIZE; i++)
                    entries[i].useful[decrBit] <= 1'b0;
                decrBit <= !decrBit;
            end
            decrCnt <= decrCnt - 1'b1;
        end
    end
endmodule

//--- src/tage_defines.svh
`ifndef TAGE_DEFINES_SVH
`define TAGE_DEFINES_SVH

// base table entries.
`define BIM_SIZE 256
// entries per tagged table.
`define TAGE_SIZE 64

`define TAG1_W 9
`define TAG2_W 11

// global history bits seen by each tagged table.
`define HIST1_LEN 8
`define HIST2_LEN 16

`define USF_W 2
`define CNT_W 2

// width of the aging down-counter, kept small so aging happens often.
`define AGE_INTERVAL 10

`endif

//--- test/tagePredictor_chk.sv
`timescale 1ns/1ns

module tagePredictor_chk (
    input logic               clk,
    input logic               rst,
    input logic               predictValid,
    input logic               resultValid,
    input tagePkg::predMeta_t resultMeta
);
    import tagePkg::*;

    // a request always produces a result two edges later, and nothing else does.
    assert property (@(posedge clk) disable iff (rst) predictValid |-> ##2 resultValid)
        else $error("resultValid missing two cycles after predictValid");

    assert property (@(posedge clk) disable iff (rst) resultValid |-> $past(predictValid, 2))
        else $error("resultValid without a request two cycles before");

    assert property (@(posedge clk) ($past(rst) || $past(rst, 2)) |-> !resultValid)
        else $error("resultValid high during or just after reset");

    assert property (@(posedge clk) disable iff (rst)
                     resultValid |-> resultMeta.provider inside {BASE, T1, T2})
        else $error("resultMeta carries an unknown provider");
endmodule

bind tagePredictor tagePredictor_chk chk (
    .clk          (clk),
    .rst          (rst),
    .predictValid (predictValid),
    .resultValid  (resultValid),
    .resultMeta   (resultMeta)
);

//--- test/tagePredictor_tb.sv
`timescale 1ns/1ns

module tagePredictor_tb;
    import tagePkg::*;

    localparam int CHK_NONE   = 0;
    localparam int CHK_FULL   = 1; // taken and provider.
    localparam int CHK_ALT    = 2; // taken, provider and altTaken.
    localparam int CHK_TAGGED = 3; // taken equals outcome and provider is a tagged table.
    localparam int RAND_COUNT = 16;

    typedef struct {
        logic [31:0] pc;
        logic        outcome;
        logic        expectTaken;
        provider_t   expectProvider;
        logic        expectAlt;
        int          checkFlag;
    } step_t;

    logic        clk;
    logic        rst;
    logic        predictValid;
    logic [31:0] predictPc;
    logic        updateValid;
    logic [31:0] updatePc;
    logic        updateTaken;
    predMeta_t   updateMeta;
    logic        resultValid;
    logic        resultTaken;
    predMeta_t   resultMeta;

    step_t       steps[$];
    int          errors;
    int          checks;
    int          cycles;
    int          timeoutLimit;
    logic [31:0] rnd;
    int          issueQ[$];
    int          received;

    tagePredictor dut (
        .clk          (clk),
        .rst          (rst),
        .predictValid (predictValid),
        .predictPc    (predictPc),
        .updateValid  (updateValid),
        .updatePc     (updatePc),
        .updateTaken  (updateTaken),
        .updateMeta   (updateMeta),
        .resultValid  (resultValid),
        .resultTaken  (resultTaken),
        .resultMeta   (resultMeta)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > timeoutLimit) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic addStep(input logic [31:0] pc, input logic outcome, input logic expTaken,
                           input provider_t expProv, input logic expAlt, input int flag);
        step_t s;
        s.pc             = pc;
        s.outcome        = outcome;
        s.expectTaken    = expTaken;
        s.expectProvider = expProv;
        s.expectAlt      = expAlt;
        s.checkFlag      = flag;
        steps.push_back(s);
    endtask

    // taken updates fill the history with ones so later lookups repeat their history.
    task automatic buildTable();
        addStep(32'h0000_7040, 1'b0, 1'b0, BASE, 1'b0, CHK_FULL);
        for (int i = 0; i < 16; i++)
            addStep(32'h0001_2080, 1'b1, 1'b1, BASE, 1'b0, CHK_NONE);
        addStep(32'h0003_45c4, 1'b1, 1'b0, BASE, 1'b0, CHK_FULL);
        addStep(32'h0003_45c4, 1'b0, 1'b1, T1, 1'b1, CHK_ALT);
        for (int i = 0; i < 16; i++)
            addStep(32'h0001_2080, 1'b1, 1'b1, BASE, 1'b0, CHK_NONE);
        addStep(32'h0003_45c4, 1'b0, 1'b0, T2, 1'b0, CHK_ALT);
        for (int k = 0; k < 80; k++)
            addStep(32'h0005_9214, (k % 2) == 0, (k % 2) == 0, T1, 1'b0,
                    k >= 72 ? CHK_TAGGED : CHK_NONE);
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic runStep(input int idx);
        step_t     s;
        predMeta_t meta;
        s = steps[idx];
        @(posedge clk);
        #1;
        predictValid = 1'b1;
        predictPc    = s.pc;
        @(posedge clk);
        #1;
        predictValid = 1'b0;
        @(negedge clk);
        while (!resultValid)
            @(negedge clk);
        meta = resultMeta;
        if (s.checkFlag == CHK_FULL || s.checkFlag == CHK_ALT) begin
            checks++;
            if (resultTaken != s.expectTaken)
                reportError($sformatf("step %0d taken %0b, expected %0b",
                                      idx, resultTaken, s.expectTaken));
            if (meta.providerTaken != s.expectTaken)
                reportError($sformatf("step %0d providerTaken %0b, expected %0b",
                                      idx, meta.providerTaken, s.expectTaken));
            if (meta.provider != s.expectProvider)
                reportError($sformatf("step %0d provider %0d, expected %0d",
                                      idx, meta.provider, s.expectProvider));
        end
        if (s.checkFlag == CHK_ALT) begin
            if (meta.altTaken != s.expectAlt)
                reportError($sformatf("step %0d altTaken %0b, expected %0b",
                                      idx, meta.altTaken, s.expectAlt));
        end
        if (s.checkFlag == CHK_TAGGED) begin
            checks++;
            if (resultTaken != s.outcome)
                reportError($sformatf("step %0d taken %0b, outcome %0b",
                                      idx, resultTaken, s.outcome));
            if (meta.provider == BASE)
                reportError($sformatf("step %0d provider is the base table", idx));
        end
        @(posedge clk);
        #1;
        updateValid = 1'b1;
        updatePc    = s.pc;
        updateTaken = s.outcome;
        updateMeta  = meta;
        @(posedge clk);
        #1;
        updateValid = 1'b0;
    endtask

    task automatic issueRandom();
        for (int i = 0; i < RAND_COUNT; i++) begin
            @(posedge clk);
            #1;
            rnd          = nextRand(rnd);
            predictValid = 1'b1;
            predictPc    = {rnd[31:10], 2'b11, rnd[7:0]}; // base entries no step has trained.
            issueQ.push_back(cycles + 1); // count of the edge that samples this request.
        end
        @(posedge clk);
        #1;
        predictValid = 1'b0;
    endtask

    task automatic collectRandom();
        int issued;
        int latency;
        received = 0;
        while (received < RAND_COUNT) begin
            @(negedge clk);
            if (resultValid) begin
                checks++;
                issued  = issueQ.pop_front();
                latency = cycles + 1 - issued; // the next edge samples this result.
                if (latency != 2)
                    reportError($sformatf("result %0d came %0d cycles after its request",
                                          received, latency));
                if (resultTaken !== 1'b0 || resultMeta.provider != BASE)
                    reportError($sformatf("result %0d taken %0b provider %0d, expected 0 and 0",
                                          received, resultTaken, resultMeta.provider));
                received++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        predictValid = 1'b0;
        predictPc    = '0;
        updateValid  = 1'b0;
        updatePc     = '0;
        updateTaken  = 1'b0;
        updateMeta   = '0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        rnd          = 32'h9b38;
        buildTable();
        timeoutLimit = steps.size() * 6 + RAND_COUNT + 100; // each step takes five cycles.
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < steps.size(); i++)
            runStep(i);
        fork
            issueRandom();
            collectRandom();
        join
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
endmodule
